// File: verilog.f
+incdir+.
attn_pkg.sv
q_convert.sv
expmul_stage.sv
value_mem.sv
mem_arbiter.sv
online_softmax_row.sv
attn_top.sv
tb_attn_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_attn_top
RTL_TOP  = attn_top
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_attn_model.svh
/* Online softmax reference model */

`ifndef TB_ATTN_MODEL_SVH
`define TB_ATTN_MODEL_SVH

row_t   model_acc;      // Running numerator
elem_t  model_den;      // Running denominator
score_t model_m;        // Running max

// Integer log2 exponent for exp(a - b)
function automatic int est_log2_exponent(score_t a, score_t b);
    int d;
    int x;
    int est;
    int l;
    d = int'(a) - int'(b);              // Q5.4 units
    x = d >>> 2;                        // Floor to Q5.2
    if (x > 63)
        x = 63;
    if (x < -64)
        x = -64;
    est = x + (x >>> 1) - (x >>> 4);    // Roughly x * 1.4375
    l = est >>> 2;                      // Floor to an integer
    if (l > 15)
        l = 15;
    if (l < -16)
        l = -16;                        // Very large gaps clamp here
    return l;
endfunction

// v * 2^l with the widened shifter precision
function automatic elem_t scale_by_pow2(elem_t v, int l);
    longint w;
    longint lim;
    w = longint'(v) * 64;               // Q9.23
    if (l < 0) begin
        w = w >>> 16;                   // Low bits are lost first
        w = w * (longint'(1) << (l + 16));
    end else begin
        w = w * (longint'(1) << l);
    end
    w = w >>> 6;                        // Floor back to Q9.17
    lim = longint'(1) << (`ELEM_W - 1);
    if (w > lim - 1)
        w = lim - 1;
    if (w < -lim)
        w = -lim;
    return elem_t'(w);
endfunction

task automatic model_reset_row();
    model_acc = '0;
    model_den = '0;
    model_m   = score_t'(8'h80);      // -8.0, lowest score
endtask

// One online update with score s and value row v
task automatic model_accumulate(score_t s, row_t v);
    score_t m_new;
    int     l_old;
    int     l_new;
    elem_t  one;
    m_new = (s > model_m) ? s : model_m;
    l_old = est_log2_exponent(model_m, m_new);  // Rescale of the old sum
    l_new = est_log2_exponent(s, m_new);
    one   = elem_t'(longint'(1) << `ELEM_F);
    for (int i = 0; i < `EMBED_DIM; i++)
        model_acc[i] = scale_by_pow2(model_acc[i], l_old) + scale_by_pow2(v[i], l_new);
    model_den = scale_by_pow2(model_den, l_old) + scale_by_pow2(one, l_new);
    model_m   = m_new;
endtask

`endif

// File: tb_attn_top.sv
/* Attention row engine testbench */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module tb_attn_top import attn_pkg::*; ();
    localparam int    TIMEOUT = 200;                    // Cycles per wait
    localparam elem_t ONE     = elem_t'(1 << `ELEM_F);  // 1.0 in Q9.17

    logic                clk;
    logic                rst;
    logic                wr_vld;
    logic                wr_rdy;
    logic [`VMEM_AW-1:0] wr_addr;
    row_t                wr_row;
    logic                score_vld;
    logic                score_rdy;
    score_t              score;
    logic [`VMEM_AW-1:0] score_idx;
    logic                score_last;
    logic                out_vld;
    logic                out_rdy;
    row_t                out_vec;
    elem_t               out_den;

    row_t                shadow_mem [`VMEM_DEPTH];  // What the scratchpad should hold
    score_t              sq [$];                    // Scores of the next row
    logic [`VMEM_AW-1:0] iq [$];                    // Their value row indices

    `include "tb_attn_model.svh"

    attn_top uut (
        .clk (clk), .rst (rst),
        .wr_vld (wr_vld), .wr_rdy (wr_rdy), .wr_addr (wr_addr), .wr_row (wr_row),
        .score_vld (score_vld), .score_rdy (score_rdy), .score (score),
        .score_idx (score_idx), .score_last (score_last),
        .out_vld (out_vld), .out_rdy (out_rdy), .out_vec (out_vec), .out_den (out_den)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, longint got, longint exp);
        if (got != exp) begin
            $display("error: time %0t signal %s got %0d expected %0d", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Random elements within +-4.0
    function automatic row_t random_row();
        row_t r;
        for (int i = 0; i < `EMBED_DIM; i++)
            r[i] = elem_t'(int'($urandom_range(0, 1048575)) - 524288);
        return r;
    endfunction

    task automatic write_row(logic [`VMEM_AW-1:0] addr, row_t row);
        int cnt;
        cnt = 0;
        @(posedge clk);
        wr_vld  <= 1'b1;
        wr_addr <= addr;
        wr_row  <= row;
        @(negedge clk);
        while (!wr_rdy) begin       // May lose to the engine's read
            cnt++;
            if (cnt > TIMEOUT)
                abort_run("timeout: a value row write was never granted");
            @(negedge clk);
        end
        @(posedge clk);             // Write lands here
        wr_vld <= 1'b0;
        shadow_mem[addr] = row;
    endtask

    task automatic send_score(score_t s, logic [`VMEM_AW-1:0] idx, logic last);
        int cnt;
        cnt = 0;
        @(posedge clk);
        score_vld  <= 1'b1;
        score      <= s;
        score_idx  <= idx;
        score_last <= last;
        @(negedge clk);
        while (!score_rdy) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run("timeout: the engine never accepted a score");
            @(negedge clk);
        end
        @(posedge clk);             // Score taken on this edge
        score_vld <= 1'b0;
    endtask

    task automatic compare_output(row_t exp_vec, elem_t exp_den);
        for (int i = 0; i < `EMBED_DIM; i++)
            check_value($sformatf("out_vec[%0d]", i), longint'(out_vec[i]),
                        longint'(exp_vec[i]));
        check_value("out_den", longint'(out_den), longint'(exp_den));
    endtask

    // Waits for the row result, optionally stalls it, then takes it
    task automatic expect_result(row_t exp_vec, elem_t exp_den, int stall);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!out_vld) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run("timeout: no row result appeared");
            @(negedge clk);
        end
        check_value("score_rdy", longint'(score_rdy), longint'(0));
        compare_output(exp_vec, exp_den);
        repeat (stall) begin
            @(negedge clk);
            check_value("out_vld", longint'(out_vld), longint'(1));     // Must hold
            check_value("score_rdy", longint'(score_rdy), longint'(0));
            compare_output(exp_vec, exp_den);
        end
        @(posedge clk);
        out_rdy <= 1'b1;
        @(negedge clk);
        check_value("out_vld", longint'(out_vld), longint'(1));
        compare_output(exp_vec, exp_den);
        @(posedge clk);             // Result taken
        out_rdy <= 1'b0;
    endtask

    // Sends the queued scores, the last one flagged, and checks the result
    task automatic stream_row(int stall);
        int n;
        n = sq.size();
        for (int k = 0; k < n; k++) begin
            send_score(sq[k], iq[k], k == n - 1);
            model_accumulate(sq[k], shadow_mem[iq[k]]);
        end
        expect_result(model_acc, model_den, stall);
        model_reset_row();
        sq.delete();
        iq.delete();
    endtask

    task automatic test_single_score();
        int cnt;
        cnt = 0;
        @(negedge clk);
        check_value("out_vld", longint'(out_vld), longint'(0));
        while (!score_rdy) begin
            cnt++;
            if (cnt > TIMEOUT)
                abort_run("timeout: score_rdy did not rise after reset");
            @(negedge clk);
        end
        write_row(4'd5, random_row());
        send_score(score_t'(8'h13), 4'd5, 1'b1);
        expect_result(shadow_mem[5], ONE, 0);       // Zero shift, row comes back as is
    endtask

    task automatic test_rising_scores();
        sq = '{score_t'(8'hf0), score_t'(8'h00), score_t'(8'h0c), score_t'(8'h1a),
               score_t'(8'h2f)};
        iq = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4};
        stream_row(0);
    endtask

    // Max set by the first score, last gap clamps the exponent
    task automatic test_falling_scores();
        sq = '{score_t'(8'h70), score_t'(8'h52), score_t'(8'h18), score_t'(8'he0),
               score_t'(8'h80)};
        iq = '{4'd5, 4'd1, 4'd2, 4'd3, 4'd4};
        stream_row(0);
    endtask

    task automatic test_output_stall();
        for (int r = 0; r < 3; r++) begin
            sq = '{score_t'(8'h10 + r * 8), score_t'(8'h30), score_t'(8'h08)};
            iq = '{4'(r), 4'(r + 1), 4'(r + 2)};
            stream_row(int'($urandom_range(1, 12)));
        end
    endtask

    task automatic test_concurrent_writes();
        row_t pend [8];
        for (int k = 0; k < 8; k++)
            pend[k] = random_row();
        fork
            begin
                @(posedge clk);             // Row 8 meets the first read
                for (int k = 0; k < 8; k++) begin
                    if (k == 2)
                        @(posedge clk);     // Row 11 meets the second read
                    write_row(4'(8 + k), pend[k]);
                end
            end
            begin
                sq = '{score_t'(8'h20), score_t'(8'h44), score_t'(8'h3c), score_t'(8'h50)};
                iq = '{4'd0, 4'd1, 4'd2, 4'd3};
                stream_row(0);
            end
        join
        sq = '{score_t'(8'h04), score_t'(8'hf8), score_t'(8'h22), score_t'(8'h10)};
        iq = '{4'd8, 4'd9, 4'd10, 4'd11};   // Rows written above
        stream_row(0);
    endtask

    initial begin
        void'($urandom(32'h5f78));
        rst        = 1'b1;
        wr_vld     = 1'b0;
        wr_addr    = '0;
        wr_row     = '0;
        score_vld  = 1'b0;
        score      = '0;
        score_idx  = '0;
        score_last = 1'b0;
        out_rdy    = 1'b0;
        model_reset_row();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_single_score();
        for (int a = 0; a < 8; a++)
            write_row(4'(a), random_row());
        test_rising_scores();
        test_falling_scores();
        test_output_stall();
        test_concurrent_writes();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: attn_top.sv
/* Attention row engine top */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module attn_top import attn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Host loader
    input  logic                wr_vld,
    output logic                wr_rdy,
    input  logic [`VMEM_AW-1:0] wr_addr,
    input  row_t                wr_row,
    // Score stream
    input  logic                score_vld,
    output logic                score_rdy,
    input  score_t              score,
    input  logic [`VMEM_AW-1:0] score_idx,
    input  logic                score_last,
    // Row result
    output logic                out_vld,
    input  logic                out_rdy,
    output row_t                out_vec,
    output elem_t               out_den
);
    logic                mem_en;
    logic                mem_we;
    logic [`VMEM_AW-1:0] mem_addr;
    row_t                mem_wdata;
    row_t                mem_rdata;
    logic                rd_vld;
    logic                rd_rdy;
    logic [`VMEM_AW-1:0] rd_addr;
    logic                rd_data_vld;
    row_t                rd_row;

    mem_arbiter u_arb (
        .clk (clk), .rst (rst),
        .wr_vld (wr_vld), .wr_rdy (wr_rdy), .wr_addr (wr_addr), .wr_row (wr_row),
        .rd_vld (rd_vld), .rd_rdy (rd_rdy), .rd_addr (rd_addr),
        .rd_data_vld (rd_data_vld), .rd_row (rd_row),
        .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr),
        .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
    );

    value_mem u_vmem (
        .clk (clk), .en (mem_en), .we (mem_we), .addr (mem_addr),
        .wdata (mem_wdata), .rdata (mem_rdata)
    );

    online_softmax_row u_row (
        .clk (clk), .rst (rst),
        .score_vld (score_vld), .score_rdy (score_rdy), .score (score),
        .score_idx (score_idx), .score_last (score_last),
        .rd_vld (rd_vld), .rd_rdy (rd_rdy), .rd_addr (rd_addr),
        .rd_data_vld (rd_data_vld), .rd_row (rd_row),
        .out_vld (out_vld), .out_rdy (out_rdy), .out_vec (out_vec), .out_den (out_den)
    );

endmodule

// File: online_softmax_row.sv
/* Online softmax row engine */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module online_softmax_row import attn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Score stream
    input  logic                score_vld,
    output logic                score_rdy,
    input  score_t              score,          // Q4.4
    input  logic [`VMEM_AW-1:0] score_idx,      // Value row for this score
    input  logic                score_last,
    // Value row reads through the arbiter
    output logic                rd_vld,
    input  logic                rd_rdy,
    output logic [`VMEM_AW-1:0] rd_addr,
    input  logic                rd_data_vld,
    input  row_t                rd_row,
    // Row result
    output logic                out_vld,
    input  logic                out_rdy,
    output row_t                out_vec,        // Unnormalized sum
    output elem_t               out_den         // Softmax denominator
);
    localparam elem_t  ELEM_ONE  = elem_t'(1 << `ELEM_F);                  // 1.0 in Q9.17
    localparam score_t SCORE_MIN = {1'b1, {(`SCORE_W-1){1'b0}}};     // -8.0

    typedef enum logic [2:0] {
        S_CLEAR,    // Reset the row state
        S_IDLE,     // Wait for a score
        S_FETCH,    // Request V[idx]
        S_WAIT,     // Wait for read data
        S_LAUNCH,   // Push into both expmul stages
        S_EXP,      // Wait for both results
        S_OUT       // Present the row result
    } state_t;

    state_t state;
    score_t m;          // Running max
    score_t m_new;      // Max including the current score
    score_t s_q;        // Current score
    logic   last_q;
    row_t   v_row;      // Fetched value row
    vec_t   acc;        // Running sum, last slot is the denominator
    vec_t   v_ext;      // Value row with 1.0 appended
    vec_t   acc_scaled;
    vec_t   v_scaled;
    logic   launch;
    logic   take;
    logic   e0_rdy;
    logic   e1_rdy;
    logic   e0_vld;
    logic   e1_vld;

    assign score_rdy = (state == S_IDLE);
    assign rd_vld    = (state == S_FETCH);
    assign out_vld   = (state == S_OUT);
    assign launch    = (state == S_LAUNCH) && e0_rdy && e1_rdy;  // Both accept together
    assign take      = (state == S_EXP) && e0_vld && e1_vld;     // Both drain together
    assign v_ext     = {ELEM_ONE, v_row};
    assign out_vec   = acc[`EMBED_DIM-1:0];
    assign out_den   = acc[`EMBED_DIM];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_CLEAR;
        end else begin
            case (state)
                S_CLEAR:  state <= S_IDLE;
                S_IDLE:   if (score_vld) state <= S_FETCH;
                S_FETCH:  if (rd_rdy) state <= S_WAIT;
                S_WAIT:   if (rd_data_vld) state <= S_LAUNCH;
                S_LAUNCH: if (launch) state <= S_EXP;
                S_EXP:    if (take) state <= last_q ? S_OUT : S_IDLE;
                S_OUT:    if (out_rdy) state <= S_CLEAR;
                default:  state <= S_CLEAR;
            endcase
        end
    end

    // Row datapath
    always_ff @(posedge clk) begin
        case (state)
            S_CLEAR: begin
                acc <= '0;
                m   <= SCORE_MIN;
            end
            S_IDLE: begin
                if (score_vld) begin
                    s_q     <= score;
                    rd_addr <= score_idx;
                    last_q  <= score_last;
                    m_new   <= (score > m) ? score : m;
                end
            end
            S_WAIT: begin
                if (rd_data_vld)
                    v_row <= rd_row;
            end
            S_EXP: begin
                if (take) begin
                    for (int i = 0; i <= `EMBED_DIM; i++)
                        acc[i] <= acc_scaled[i] + v_scaled[i];
                    m <= m_new;
                end
            end
            default: ;
        endcase
    end

    // acc * exp(m - m_new)
    expmul_stage u_rescale (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (launch),
        .rdy_in  (take),
        .vld_out (e0_vld),
        .rdy_out (e0_rdy),
        .a_in    (m),
        .b_in    (m_new),
        .v_in    (acc),
        .v_out   (acc_scaled)
    );

    // [V, 1] * exp(s - m_new)
    expmul_stage u_scale (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (launch),
        .rdy_in  (take),
        .vld_out (e1_vld),
        .rdy_out (e1_rdy),
        .a_in    (s_q),
        .b_in    (m_new),
        .v_in    (v_ext),
        .v_out   (v_scaled)
    );

endmodule

// File: mem_arbiter.sv
/* Scratchpad round-robin arbiter */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module mem_arbiter import attn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Host write port
    input  logic                wr_vld,
    output logic                wr_rdy,
    input  logic [`VMEM_AW-1:0] wr_addr,
    input  row_t                wr_row,
    // Engine read port
    input  logic                rd_vld,
    output logic                rd_rdy,
    input  logic [`VMEM_AW-1:0] rd_addr,
    output logic                rd_data_vld,
    output row_t                rd_row,
    // Scratchpad side
    output logic                mem_en,
    output logic                mem_we,
    output logic [`VMEM_AW-1:0] mem_addr,
    output row_t                mem_wdata,
    input  row_t                mem_rdata
);
    logic last_wr;      // Write won the last grant
    logic grant_wr;
    logic grant_rd;

    // On a tie the port that lost last time wins
    assign grant_wr = wr_vld && (!rd_vld || !last_wr);
    assign grant_rd = rd_vld && !grant_wr;

    assign wr_rdy    = grant_wr;
    assign rd_rdy    = grant_rd;
    assign mem_en    = grant_wr || grant_rd;
    assign mem_we    = grant_wr;
    assign mem_addr  = grant_wr ? wr_addr : rd_addr;
    assign mem_wdata = wr_row;
    assign rd_row    = mem_rdata;       // Registered inside value_mem

    always_ff @(posedge clk) begin
        if (rst) begin
            last_wr     <= 1'b0;
            rd_data_vld <= 1'b0;
        end else begin
            if (mem_en)
                last_wr <= grant_wr;
            rd_data_vld <= grant_rd;    // Read data one cycle after grant
        end
    end

endmodule

// File: value_mem.sv
/* Value row scratchpad */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module value_mem (
    input  logic                            clk,
    input  logic                            en,     // Access this cycle
    input  logic                            we,     // Write, else read
    input  logic [`VMEM_AW-1:0]             addr,
    input  logic [`EMBED_DIM*`ELEM_W-1:0]   wdata,
    output logic [`EMBED_DIM*`ELEM_W-1:0]   rdata   // Valid one cycle after a read
);
    // One row per value vector
    logic [`EMBED_DIM*`ELEM_W-1:0] mem [`VMEM_DEPTH];

    // Single port, write or read per cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];     // Registered read
        end
    end

endmodule

// File: expmul_stage.sv
/* Exp-by-shift multiply pipeline */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module expmul_stage import attn_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   vld_in,      // Upstream offers a_in, b_in
    input  logic   rdy_in,      // Downstream takes v_out
    output logic   vld_out,
    output logic   rdy_out,
    input  score_t a_in,        // Q4.4
    input  score_t b_in,        // Q4.4, usually the new max
    input  vec_t   v_in,        // Q9.17, held until the output is taken
    output vec_t   v_out        // v_in * 2^l_hat
);
    localparam int PAD_W  = `SHIFT_W - `ELEM_W;        // Extra fraction bits
    localparam int ELEM_I = `ELEM_W - `ELEM_F;
    localparam int SH_F   = `SHIFT_W - ELEM_I;
    localparam int SC_I   = `SCORE_W - `SCORE_F;

    score_t            a_q;
    score_t            b_q;
    diff_t             d;           // Q5.4
    logic signed [6:0] d_q52;       // Q5.2
    logic signed [7:0] d_q62;       // Q6.2, room for the sum
    logic signed [7:0] log_est;     // Q6.2, d * log2(e)
    exp_t              l_hat_next;
    exp_t              l_hat;
    logic              s1_vld;
    logic              s2_vld;
    logic              s1_rdy;
    logic              s2_rdy;

    // Standard two-slot pipeline flow
    assign s2_rdy  = !s2_vld || rdy_in;
    assign s1_rdy  = !s1_vld || s2_rdy;
    assign rdy_out = s1_rdy;
    assign vld_out = s2_vld;

    assign d = diff_t'(a_q) - diff_t'(b_q);

    // Stage 1 holds the operands
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (vld_in && s1_rdy) begin
            s1_vld <= 1'b1;
        end else if (s2_rdy) begin
            s1_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (vld_in && s1_rdy) begin
            a_q <= a_in;
            b_q <= b_in;
        end
    end

    q_convert #(.IN_I(SC_I+1), .IN_F(`SCORE_F), .OUT_I(5), .OUT_F(2)) u_diff_cvt (
        .in  (d),
        .out (d_q52)
    );

    q_convert #(.IN_I(5), .IN_F(2), .OUT_I(6), .OUT_F(2)) u_diff_ext (
        .in  (d_q52),
        .out (d_q62)
    );

    // x + x/2 - x/16, about 1.4375 * x
    assign log_est = d_q62 + (d_q62 >>> 1) - (d_q62 >>> 4);

    q_convert #(.IN_I(6), .IN_F(2), .OUT_I(5), .OUT_F(0)) u_lhat_cvt (
        .in  (log_est),
        .out (l_hat_next)           // Floor, saturates to [-16, 15]
    );

    // Stage 2 holds the exponent
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld <= 1'b0;
        end else if (s2_rdy) begin
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_rdy && s1_vld)
            l_hat <= l_hat_next;
    end

    // Barrel shift per element, combinational on v_in
    for (genvar i = 0; i <= `EMBED_DIM; i++) begin : g_elem
        shift_elem_t w0;
        shift_elem_t w1;
        shift_elem_t w2;
        shift_elem_t w3;
        shift_elem_t w4;
        shift_elem_t w5;

        assign w0 = {v_in[i], {PAD_W{1'b0}}};       // Q9.17 -> Q9.23
        assign w1 = l_hat[4] ? (w0 >>> 16) : w0;    // Sign bit, -16
        assign w2 = l_hat[3] ? (w1 <<< 8) : w1;
        assign w3 = l_hat[2] ? (w2 <<< 4) : w2;
        assign w4 = l_hat[1] ? (w3 <<< 2) : w3;
        assign w5 = l_hat[0] ? (w4 <<< 1) : w4;

        q_convert #(.IN_I(ELEM_I), .IN_F(SH_F), .OUT_I(ELEM_I), .OUT_F(`ELEM_F)) u_trunc (
            .in  (w5),
            .out (v_out[i])         // Truncate back to Q9.17
        );
    end

endmodule

// File: q_convert.sv
/* Fixed-point format converter */

`timescale 1ns/1ns
`include "attn_cfg.svh"

module q_convert #(
    parameter int IN_I  = 5,    // Integer bits incl. sign
    parameter int IN_F  = 4,
    parameter int OUT_I = 5,
    parameter int OUT_F = 2
) (
    input  logic signed [IN_I+IN_F-1:0]   in,
    output logic signed [OUT_I+OUT_F-1:0] out
);
    localparam int OUT_W  = OUT_I + OUT_F;
    localparam int FRAC   = (IN_F > OUT_F) ? IN_F : OUT_F;   // Common binary point
    localparam int WIDE_W = ((IN_I > OUT_I) ? IN_I : OUT_I) + FRAC + 1;

    // Output range limits at the wide width
    localparam logic signed [WIDE_W-1:0] MAX_V =
        {{(WIDE_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
    localparam logic signed [WIDE_W-1:0] MIN_V = ~MAX_V;

    logic signed [WIDE_W-1:0] wide;     // Input at FRAC fraction bits
    logic signed [WIDE_W-1:0] aligned;  // At OUT_F fraction bits

    always_comb begin
        wide    = WIDE_W'(in) <<< (FRAC - IN_F);  // Sign-extend, then align
        aligned = wide >>> (FRAC - OUT_F);        // Floors dropped fraction
        if (aligned > MAX_V)
            out = MAX_V[OUT_W-1:0];               // Clamp high
        else if (aligned < MIN_V)
            out = MIN_V[OUT_W-1:0];               // Clamp low
        else
            out = aligned[OUT_W-1:0];
    end

endmodule

// File: attn_pkg.sv
/* Attention row engine types */

`include "attn_cfg.svh"

package attn_pkg;

    // Q4.4 score
    typedef logic signed [`SCORE_W-1:0] score_t;

    // Q5.4, one guard bit over the score
    typedef logic signed [`SCORE_W:0] diff_t;

    // Integer log2 exponent, bit 4 weighs -16
    typedef logic signed [4:0] exp_t;

    // Q9.17 vector element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // Q9.23 widened element for the shifter
    typedef logic signed [`SHIFT_W-1:0] shift_elem_t;

    // Extended vector, element EMBED_DIM is the denominator
    typedef elem_t [`EMBED_DIM:0] vec_t;

    // Row as stored in the scratchpad
    typedef elem_t [`EMBED_DIM-1:0] row_t;

endpackage

// File: attn_cfg.svh
/* Attention row engine configuration */

`ifndef ATTN_CFG_SVH
`define ATTN_CFG_SVH

// Value elements per row, the denominator slot comes on top
`define EMBED_DIM 4

// Value scratchpad geometry
`define VMEM_DEPTH 16
`define VMEM_AW 4

// Q9.17 vector element
`define ELEM_W 26
`define ELEM_F 17
`define SHIFT_W 32      // Q9.23 inside the barrel shifter

// Q4.4 score
`define SCORE_W 8
`define SCORE_F 4

`endif
